/* Makefile */
SIM     := verilator
FLAGS   := --binary --timing --assert -Wno-fatal
TOP     := arithUnitTb
FLIST   := flist.f

OBJDIR  := obj_dir
BIN     := $(OBJDIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FLIST))
HEADERS := $(wildcard verilog/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "All tests passed!"

clean:
	rm -rf $(OBJDIR)

/* flist.f */
+incdir+verilog
verilog/arithPkg.sv
verilog/aluCore.sv
verilog/accDatapath.sv
verilog/arithSequencer.sv
verilog/arithRegBlock.sv
verilog/arithUnitTop.sv
tb/arithUnit_properties.sv
tb/arithUnitTb.sv

/* tb/arithUnitTb.sv */
// testbench for the arithmetic unit with AXI tasks, directed tests and a cycle timeout
`timescale 1ns/1ps
`include "arith_consts.svh"

module arithUnitTb import arithPkg::*; ();

    localparam int MAX_CYCLES = 20000;   // all tests take a few thousand cycles

    logic                       clock = 1'b0;
    logic                       reset;
    logic [`AXI_ADDR_WIDTH-1:0] awaddr, araddr;
    logic [`AXI_DATA_WIDTH-1:0] wdata, rdata;
    logic                       awvalid, wvalid, bready, arvalid, rready;
    logic                       awready, wready, bvalid, arready, rvalid;
    logic [1:0]                 bresp, rresp;
    logic [31:0]                rngState;
    int                         cycles = 0;

    arithUnitTop i_dut (.*);

    always #4 clock = ~clock;

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Simulation did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failures found");
            $fatal(1, "timeout");
        end
    end

    task automatic stopOnError(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic expectEqual(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else
            stopOnError($sformatf("Mismatch at %0d ns: %s is %0h, expected %0h",
                                  $time, what, got, exp));
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [7:0] randomByte();
        rngState = xorshift32(rngState);
        return rngState[7:0];
    endfunction

    // CTRL read layout
    function automatic logic [31:0] statusWord(input arithOp op, input logic c, input logic z);
        return {25'd0, op, 1'b0, z, c, 1'b0};
    endfunction

    // called on a falling edge, returns on one; hold keeps bready low that many cycles
    task automatic axiWrite(input logic [3:0] addr, input logic [31:0] data,
                            input logic [1:0] expResp, input int hold);
        logic [1:0] resp;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        do @(negedge clock); while (!(awready && wready));
        @(negedge clock);   // handshake edge passed
        awvalid = 1'b0;
        wvalid  = 1'b0;
        assert (bvalid) else stopOnError("no write response after the write handshake");
        resp = bresp;
        repeat (hold) begin
            @(negedge clock);
            assert (bvalid && bresp == resp) else
                stopOnError("write response changed while bready was low");
        end
        expectEqual($sformatf("bresp at offset %0h", addr), 32'(resp), 32'(expResp));
        bready = 1'b1;
        @(negedge clock);
        bready = 1'b0;
        assert (!bvalid) else stopOnError("bvalid stayed high after bready");
    endtask

    task automatic axiRead(input logic [3:0] addr, output logic [31:0] data, input int hold);
        araddr  = addr;
        arvalid = 1'b1;
        do @(negedge clock); while (!arready);
        @(negedge clock);
        arvalid = 1'b0;
        assert (rvalid && rresp == 2'b00) else stopOnError("no OKAY read response");
        data = rdata;
        repeat (hold) begin
            @(negedge clock);
            assert (rvalid && rdata == data) else
                stopOnError("read data changed while rready was low");
        end
        rready = 1'b1;
        @(negedge clock);
        rready = 1'b0;
        assert (!rvalid) else stopOnError("rvalid stayed high after rready");
    endtask

    task automatic waitIdle();
        logic [31:0] status;
        do axiRead(`REG_CTRL, status, 0); while (status[0]);
    endtask

    task automatic startAndWait(input arithOp op);
        logic [31:0] status;
        axiWrite(`REG_CTRL, (32'd1 << `CTRL_START) | 32'(op), 2'b00, 0);
        if (op == opMul) begin
            axiRead(`REG_CTRL, status, 0);   // multiply is still running here
            expectEqual("busy right after start", 32'(status[0]), 32'd1);
        end
        waitIdle();
    endtask

    task automatic aluCase(input arithOp op, input logic [7:0] a, input logic [7:0] d);
        logic [8:0]  full;   // carry and result
        logic [31:0] got;
        case (op)
            opAdd:   full = 9'(a) + 9'(d);
            opSub:   full = {a >= d, 8'(a - d)};   // carry means no borrow
            opAnd:   full = {1'b0, a & d};
            opOr:    full = {1'b0, a | d};
            opXor:   full = {1'b0, a ^ d};
            default: full = {1'b0, d};
        endcase
        axiWrite(`REG_ACC, 32'(a), 2'b00, 0);
        axiWrite(`REG_DR, 32'(d), 2'b00, 0);
        startAndWait(op);
        axiRead(`REG_ACC, got, 0);
        expectEqual($sformatf("Acc after op %0d on %0h, %0h", op, a, d), got, 32'(full[7:0]));
        axiRead(`REG_CTRL, got, 0);
        expectEqual($sformatf("status after op %0d", op), got,
                    statusWord(op, full[8], full[7:0] == 8'd0));
    endtask

    task automatic mulCase(input logic [7:0] m, input logic [7:0] d);
        logic [15:0] product;
        logic [31:0] got;
        product = 16'(m) * 16'(d);
        axiWrite(`REG_MQ, 32'(m), 2'b00, 0);
        axiWrite(`REG_DR, 32'(d), 2'b00, 0);
        axiWrite(`REG_ACC, 32'(randomByte()), 2'b00, 0);   // start must clear this
        startAndWait(opMul);
        axiRead(`REG_ACC, got, 0);
        expectEqual($sformatf("product high of %0h x %0h", m, d), got, 32'(product[15:8]));
        axiRead(`REG_MQ, got, 0);
        expectEqual($sformatf("product low of %0h x %0h", m, d), got, 32'(product[7:0]));
        axiRead(`REG_CTRL, got, 0);
        expectEqual("status after multiply", got, statusWord(opMul, 1'b0, product == 16'd0));
    endtask

    task automatic testReset();
        logic [31:0] got;
        for (int a = 0; a < 16; a += 4) begin
            axiRead(4'(a), got, 0);
            expectEqual($sformatf("offset %0h after reset", a), got, 32'd0);
        end
    endtask

    task automatic testLoads();
        logic [31:0] value;
        logic [31:0] got;
        repeat (4) begin
            for (int a = 0; a < 12; a += 4) begin
                value = {randomByte(), randomByte(), randomByte(), randomByte()};
                axiWrite(4'(a), value, 2'b00, 0);
                axiRead(4'(a), got, 0);
                expectEqual($sformatf("readback at offset %0h", a), got, 32'(value[7:0]));
            end
        end
    endtask

    task automatic testAluOps();
        for (int op = 0; op < 6; op++) begin
            aluCase(arithOp'(op), randomByte(), randomByte());
        end
        aluCase(opAdd, 8'hF0, 8'h35);   // overflow
        aluCase(opSub, 8'h10, 8'h20);   // borrow
        aluCase(opXor, 8'h5A, 8'h5A);
        aluCase(opSub, 8'h77, 8'h77);
    endtask

    task automatic testMultiply();
        mulCase(8'h00, randomByte());
        mulCase(randomByte(), 8'h00);
        mulCase(8'hFF, 8'hFF);
        mulCase(8'h01, randomByte());
        mulCase(randomByte(), 8'h01);
        repeat (6) mulCase(randomByte(), randomByte());
    endtask

    task automatic testBusy();
        logic [7:0]  m;
        logic [7:0]  d;
        logic [15:0] product;
        logic [31:0] got;
        m = randomByte() | 8'h01;
        d = randomByte();
        product = 16'(m) * 16'(d);
        axiWrite(`REG_MQ, 32'(m), 2'b00, 0);
        axiWrite(`REG_DR, 32'(d), 2'b00, 0);
        axiWrite(`REG_CTRL, (32'd1 << `CTRL_START) | 32'(opMul), 2'b00, 0);
        axiWrite(`REG_DR, 32'(~d), 2'b10, 0);
        axiWrite(`REG_CTRL, (32'd1 << `CTRL_START) | 32'(opAdd), 2'b10, 0);
        waitIdle();
        axiRead(`REG_DR, got, 0);
        expectEqual("DR after rejected write", got, 32'(d));
        axiRead(`REG_ACC, got, 0);
        expectEqual("product high after rejected start", got, 32'(product[15:8]));
        axiRead(`REG_MQ, got, 0);
        expectEqual("product low after rejected start", got, 32'(product[7:0]));
        axiRead(`REG_CTRL, got, 0);
        expectEqual("status after rejected start", got,
                    statusWord(opMul, 1'b0, product == 16'd0));
    endtask

    task automatic testBackPressure();
        logic [7:0]  m;
        logic [7:0]  d;
        logic [31:0] got;
        m = randomByte();
        d = randomByte();
        axiWrite(`REG_DR, 32'(d), 2'b00, 3);
        axiWrite(`REG_MQ, 32'(m), 2'b00, 5);
        axiRead(`REG_MQ, got, 6);
        expectEqual("MQ read under back-pressure", got, 32'(m));
        // multiply keeps running while the response waits
        axiWrite(`REG_CTRL, (32'd1 << `CTRL_START) | 32'(opMul), 2'b00, 12);
        waitIdle();
        axiRead(`REG_ACC, got, 4);
        expectEqual("product high under back-pressure", got, 32'(8'((16'(m) * 16'(d)) >> 8)));
    endtask

    initial begin
        rngState = 32'd75;
        reset    = 1'b1;
        awaddr   = '0;
        awvalid  = 1'b0;
        wdata    = '0;
        wvalid   = 1'b0;
        bready   = 1'b0;
        araddr   = '0;
        arvalid  = 1'b0;
        rready   = 1'b0;
        repeat (3) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        testReset();
        testLoads();
        testAluOps();
        testMultiply();
        testBusy();
        testBackPressure();
        $display("All tests passed!");
        $finish;
    end

endmodule

/* tb/arithUnit_properties.sv */
// concurrent assertions on the AXI response channels, sequencer state and the DR operand
`timescale 1ns/1ps
`include "arith_consts.svh"

module arithUnit_properties import arithPkg::*; (
    input logic                        clock,
    input logic                        reset,
    input logic                        bvalid,
    input logic                        bready,
    input logic [1:0]                  bresp,
    input logic                        rvalid,
    input logic                        rready,
    input logic [`AXI_DATA_WIDTH-1:0]  rdata,
    input logic                        busy,
    input seqState                     state,
    input logic [`DATA_WIDTH-1:0]      drValue
);

    // responses stay put until the master takes them
    assert property (@(posedge clock) disable iff (reset)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else $error("write response dropped or changed before bready");

    assert property (@(posedge clock) disable iff (reset)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else $error("read data dropped or changed before rready");

    // the FSM returns to idle only through sDone
    assert property (@(posedge clock) disable iff (reset) $fell(busy) |-> $past(state) == sDone)
        else $error("busy fell without passing through sDone");

    // operands are frozen while the FSM runs
    assert property (@(posedge clock) disable iff (reset) busy |=> $stable(drValue))
        else $error("DR changed while the unit was busy");

endmodule

bind arithUnitTop arithUnit_properties i_props (
    .clock, .reset, .bvalid, .bready, .bresp, .rvalid, .rready, .rdata,
    .busy, .state(i_sequencer.state), .drValue
);

/* verilog/accDatapath.sv */
// Acc, MQ and DR registers with host load, ALU writeback and the multiply shift
`timescale 1ns/1ps
`include "arith_consts.svh"

module accDatapath (
    input  logic                    clock,
    input  logic                    reset,
    // host side
    input  logic                    loadDr,
    input  logic                    loadMq,
    input  logic                    loadAcc,
    input  logic [`DATA_WIDTH-1:0]  loadData,
    // sequencer side
    input  logic                    writeAcc,
    input  logic                    shiftStep,
    input  logic                    clearAcc,
    // ALU side
    input  logic [`DATA_WIDTH-1:0]  result,
    input  logic [`DATA_WIDTH-1:0]  stepAcc,
    input  logic [`DATA_WIDTH-1:0]  stepMq,
    output logic [`DATA_WIDTH-1:0]  accValue,
    output logic [`DATA_WIDTH-1:0]  mqValue,
    output logic [`DATA_WIDTH-1:0]  drValue,
    output logic                    mqLsb
);

    // accumulator
    // clear wins over writeback, writeback over shift, shift over host load
    always_ff @(posedge clock) begin
        if (reset) begin
            accValue <= '0;
        end else if (clearAcc) begin
            accValue <= '0;
        end else if (writeAcc) begin
            accValue <= result;
        end else if (shiftStep) begin
            accValue <= stepAcc;
        end else if (loadAcc) begin
            accValue <= loadData;
        end
    end

    // multiplier-quotient, shifts right with the adder's low bit coming in
    always_ff @(posedge clock) begin
        if (reset) begin
            mqValue <= '0;
        end else if (shiftStep) begin
            mqValue <= stepMq;
        end else if (loadMq) begin
            mqValue <= loadData;
        end
    end

    // data register, host writes only
    always_ff @(posedge clock) begin
        if (reset) begin
            drValue <= '0;
        end else if (loadDr) begin
            drValue <= loadData;
        end
    end

    assign mqLsb = mqValue[0];   // gates the next partial product

endmodule

/* verilog/aluCore.sv */
// combinational ALU with one shared adder for the opcodes and the multiply step
`timescale 1ns/1ps
`include "arith_consts.svh"

module aluCore import arithPkg::*; (
    input  arithOp                  aluOp,
    input  logic [`DATA_WIDTH-1:0]  acc,
    input  logic [`DATA_WIDTH-1:0]  dr,
    input  logic                    mqLsb,
    input  logic [`DATA_WIDTH-1:0]  mqValue,
    output logic [`DATA_WIDTH-1:0]  result,
    output logic                    carryOut,
    output logic [`DATA_WIDTH-1:0]  stepAcc,
    output logic [`DATA_WIDTH-1:0]  stepMq
);

    logic [`DATA_WIDTH-1:0] addB;
    logic                   addCin;
    logic [`DATA_WIDTH:0]   sum;

    // second adder operand
    always_comb begin
        addCin = 1'b0;
        case (aluOp)
            opSub: begin
                addB   = ~dr;   // acc + ~dr + 1
                addCin = 1'b1;
            end
            opMul:   addB = mqLsb ? dr : '0;  // partial product only on a set multiplier bit
            default: addB = dr;
        endcase
    end

    assign sum = {1'b0, acc} + {1'b0, addB} + {{`DATA_WIDTH{1'b0}}, addCin};

    always_comb begin
        result   = dr;      // pass and the reserved code
        carryOut = 1'b0;
        case (aluOp)
            opAdd, opSub, opMul: begin
                result   = sum[`DATA_WIDTH-1:0];
                carryOut = sum[`DATA_WIDTH];   // no-borrow for subtract
            end
            opAnd: result = acc & dr;
            opOr:  result = acc | dr;
            opXor: result = acc ^ dr;
            default: begin
                result   = dr;
                carryOut = 1'b0;
            end
        endcase
    end

    // {carry, Acc, MQ} shifted right by one
    assign stepAcc = sum[`DATA_WIDTH:1];
    assign stepMq  = {sum[0], mqValue[`DATA_WIDTH-1:1]};

endmodule

/* verilog/arithPkg.sv */
// opcode and sequencer state types for the arithmetic unit
package arithPkg;

    // opcode field of the CTRL register, 7 behaves as pass
    typedef enum logic [2:0] {
        opAdd  = 3'd0,
        opSub  = 3'd1,
        opAnd  = 3'd2,
        opOr   = 3'd3,
        opXor  = 3'd4,
        opPass = 3'd5,
        opMul  = 3'd6
    } arithOp;

    // sequencer FSM
    typedef enum logic [1:0] {
        sIdle    = 2'd0,
        sExec    = 2'd1,    // single op writeback, or Acc clear before a multiply
        sMulStep = 2'd2,    // one add-and-shift per cycle
        sDone    = 2'd3
    } seqState;

endpackage

/* verilog/arithRegBlock.sv */
// AXI4-Lite slave with operand and control register decode and status readback
`timescale 1ns/1ps
`include "arith_consts.svh"

module arithRegBlock import arithPkg::*; (
    input  logic                        clock,
    input  logic                        reset,
    // AXI4-Lite write
    input  logic [`AXI_ADDR_WIDTH-1:0]  awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [`AXI_DATA_WIDTH-1:0]  wdata,
    input  logic                        wvalid,
    output logic                        wready,
    output logic [1:0]                  bresp,
    output logic                        bvalid,
    input  logic                        bready,
    // AXI4-Lite read
    input  logic [`AXI_ADDR_WIDTH-1:0]  araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output logic [`AXI_DATA_WIDTH-1:0]  rdata,
    output logic [1:0]                  rresp,
    output logic                        rvalid,
    input  logic                        rready,
    // unit status
    input  logic                        busy,
    input  logic                        carryFlag,
    input  logic                        zeroFlag,
    input  arithOp                      lastOp,
    input  logic [`DATA_WIDTH-1:0]      accValue,
    input  logic [`DATA_WIDTH-1:0]      mqValue,
    input  logic [`DATA_WIDTH-1:0]      drValue,
    // commands
    output logic                        loadDr,
    output logic                        loadMq,
    output logic                        loadAcc,
    output logic [`DATA_WIDTH-1:0]      loadData,
    output logic                        start,
    output arithOp                      opcode
);

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;
    localparam int         PAD_BYTE    = `AXI_DATA_WIDTH - `DATA_WIDTH;

    logic                       wrReady;
    logic                       wrFire;
    logic                       wrMapped;
    logic                       wrOk;
    logic                       rdFire;
    logic [`AXI_DATA_WIDTH-1:0] readWord;

    // address and data are taken in the same cycle
    assign awready = wrReady;
    assign wready  = wrReady;
    assign wrFire  = awvalid && wvalid && wrReady;
    assign rdFire  = arvalid && arready;

    assign wrMapped = (awaddr == `REG_DR) || (awaddr == `REG_MQ) ||
                      (awaddr == `REG_ACC) || (awaddr == `REG_CTRL);
    assign wrOk     = wrFire && !busy;   // operands frozen while the unit runs

    assign loadDr   = wrOk && (awaddr == `REG_DR);
    assign loadMq   = wrOk && (awaddr == `REG_MQ);
    assign loadAcc  = wrOk && (awaddr == `REG_ACC);
    assign start    = wrOk && (awaddr == `REG_CTRL) && wdata[`CTRL_START];
    assign loadData = wdata[`DATA_WIDTH-1:0];   // low byte only
    assign opcode   = arithOp'(wdata[2:0]);

    // write channel control
    always_ff @(posedge clock) begin
        if (reset) begin
            wrReady <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            wrReady <= awvalid && wvalid && !bvalid && !wrReady;  // one-cycle pulse
            if (wrFire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (wrFire) begin
            bresp <= (wrMapped && busy) ? RESP_SLVERR : RESP_OKAY;
        end
    end

    // read mux, status word is busy/carry/zero in 2:0 and opcode in 6:4
    always_comb begin
        case (araddr)
            `REG_DR:   readWord = {{PAD_BYTE{1'b0}}, drValue};
            `REG_MQ:   readWord = {{PAD_BYTE{1'b0}}, mqValue};
            `REG_ACC:  readWord = {{PAD_BYTE{1'b0}}, accValue};
            `REG_CTRL: readWord = {{(`AXI_DATA_WIDTH - 7){1'b0}}, lastOp, 1'b0,
                                   zeroFlag, carryFlag, busy};
            default:   readWord = '0;
        endcase
    end

    // read channel control
    always_ff @(posedge clock) begin
        if (reset) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= arvalid && !rvalid && !arready;
            if (rdFire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (rdFire) begin
            rdata <= readWord;   // held stable until rready
        end
    end

    assign rresp = RESP_OKAY;

endmodule

/* verilog/arithSequencer.sv */
// control FSM for single ALU operations and the shift-and-add multiply, with flags
`timescale 1ns/1ps
`include "arith_consts.svh"

module arithSequencer import arithPkg::*; (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    start,
    input  arithOp                  opcode,
    input  logic                    mqLsb,
    input  logic                    carryOut,
    input  logic [`DATA_WIDTH-1:0]  result,
    input  logic [`DATA_WIDTH-1:0]  stepAcc,
    input  logic [`DATA_WIDTH-1:0]  stepMq,
    output logic                    busy,
    output logic                    carryFlag,
    output logic                    zeroFlag,
    output arithOp                  lastOp,
    output arithOp                  aluOp,
    output logic                    writeAcc,
    output logic                    shiftStep,
    output logic                    clearAcc
);

    localparam int STEP_BITS = $clog2(`MUL_STEPS);

    seqState              state;
    logic [STEP_BITS-1:0] stepCount;
    logic                 mulAdded;   // some partial product was added so far
    logic                 lastStep;
    logic                 anyAdd;

    assign lastStep = (stepCount == STEP_BITS'(`MUL_STEPS - 1));
    assign anyAdd   = mulAdded | mqLsb;

    always_ff @(posedge clock) begin
        if (reset) begin
            state     <= sIdle;
            stepCount <= '0;
            mulAdded  <= 1'b0;
            lastOp    <= opAdd;
            carryFlag <= 1'b0;
            zeroFlag  <= 1'b0;
        end else begin
            case (state)
                sIdle: begin
                    if (start) begin
                        lastOp <= opcode;   // held for the status read too
                        state  <= sExec;
                    end
                end
                sExec: begin
                    stepCount <= '0;
                    mulAdded  <= 1'b0;
                    if (lastOp == opMul) begin
                        state <= sMulStep;   // Acc is cleared on this edge
                    end else begin
                        carryFlag <= carryOut;
                        zeroFlag  <= (result == '0);
                        state     <= sDone;
                    end
                end
                sMulStep: begin
                    stepCount <= stepCount + 1'b1;
                    mulAdded  <= anyAdd;
                    if (lastStep) begin
                        carryFlag <= 1'b0;
                        // zero multiplier never adds, otherwise look at the full product
                        zeroFlag  <= !anyAdd || ({stepAcc, stepMq} == '0);
                        state     <= sDone;
                    end
                end
                sDone:   state <= sIdle;
                default: state <= sIdle;
            endcase
        end
    end

    assign busy      = (state != sIdle);
    assign aluOp     = lastOp;
    assign writeAcc  = (state == sExec) && (lastOp != opMul);
    assign clearAcc  = (state == sExec) && (lastOp == opMul);
    assign shiftStep = (state == sMulStep);

endmodule

/* verilog/arithUnitTop.sv */
// top level of the arithmetic unit: register block, sequencer, datapath and ALU
`timescale 1ns/1ps
`include "arith_consts.svh"

module arithUnitTop import arithPkg::*; (
    input  logic                        clock,
    input  logic                        reset,
    input  logic [`AXI_ADDR_WIDTH-1:0]  awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [`AXI_DATA_WIDTH-1:0]  wdata,
    input  logic                        wvalid,
    output logic                        wready,
    output logic [1:0]                  bresp,
    output logic                        bvalid,
    input  logic                        bready,
    input  logic [`AXI_ADDR_WIDTH-1:0]  araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output logic [`AXI_DATA_WIDTH-1:0]  rdata,
    output logic [1:0]                  rresp,
    output logic                        rvalid,
    input  logic                        rready
);

    logic                   loadDr, loadMq, loadAcc, start;
    logic [`DATA_WIDTH-1:0] loadData;
    arithOp                 opcode, lastOp, aluOp;
    logic                   busy, carryFlag, zeroFlag;
    logic                   writeAcc, shiftStep, clearAcc;
    logic [`DATA_WIDTH-1:0] accValue, mqValue, drValue;
    logic                   mqLsb, carryOut;
    logic [`DATA_WIDTH-1:0] result, stepAcc, stepMq;

    arithRegBlock i_regBlock (
        .clock, .reset,
        .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
        .busy, .carryFlag, .zeroFlag, .lastOp, .accValue, .mqValue, .drValue,
        .loadDr, .loadMq, .loadAcc, .loadData, .start, .opcode
    );

    arithSequencer i_sequencer (
        .clock, .reset, .start, .opcode, .mqLsb, .carryOut, .result, .stepAcc, .stepMq,
        .busy, .carryFlag, .zeroFlag, .lastOp, .aluOp, .writeAcc, .shiftStep, .clearAcc
    );

    accDatapath i_datapath (
        .clock, .reset, .loadDr, .loadMq, .loadAcc, .loadData,
        .writeAcc, .shiftStep, .clearAcc, .result, .stepAcc, .stepMq,
        .accValue, .mqValue, .drValue, .mqLsb
    );

    aluCore i_alu (
        .aluOp, .acc(accValue), .dr(drValue), .mqLsb, .mqValue,
        .result, .carryOut, .stepAcc, .stepMq
    );

endmodule

/* verilog/arith_consts.svh */
// width, AXI bus and register map constants for the arithmetic unit
`ifndef ARITH_CONSTS_SVH
`define ARITH_CONSTS_SVH

// operand width, also the multiplier length
`define DATA_WIDTH      8

`define AXI_ADDR_WIDTH  4
`define AXI_DATA_WIDTH  32

// register map
`define REG_DR          4'h0
`define REG_MQ          4'h4
`define REG_ACC         4'h8
`define REG_CTRL        4'hC
`define CTRL_START      8       // start bit in a CTRL write

`define MUL_STEPS       8       // one iteration per multiplier bit

`endif
